// ==== lc3Settings.svh ====
`ifndef LC3_SETTINGS_SVH
`define LC3_SETTINGS_SVH

// Data path and address width
`define LC3_WORD_BITS 16

// General purpose registers R0..R7
`define LC3_NUM_REGS 8

// Start address, loaded into PC while halted
`define LC3_PC_RESET 16'h0200

// Address bits decoded by the memory model
`define LC3_MEM_ADDR_BITS 10

`endif

// ==== lc3IsaPkg.sv ====
`default_nettype none

`include "lc3Settings.svh"

package lc3IsaPkg;

    // One machine word, data or address
    typedef logic [`LC3_WORD_BITS-1:0] word_t;

    typedef logic [$clog2(`LC3_NUM_REGS)-1:0] regIdx_t;

    // Supported opcodes, anything else traps to INVALID
    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_AND = 4'b0101,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100
    } opcode_t;

    // N, Z, P from msb to lsb
    typedef logic [2:0] cc_t;

endpackage

`default_nettype wire

// ==== lc3CtrlPkg.sv ====
`default_nettype none

package lc3CtrlPkg;

    typedef enum logic [3:0] {
        HALT, START,
        FETCH, FETCH_WAIT, LOAD_IR, DECODE,
        BR_TEST, BR_TAKE,
        ALU_OP,
        JMP_PC,
        ADDR_MAR, LD_WAIT, LD_REG,
        ST_MDR, ST_WAIT,
        INVALID
    } ctrlState_t;

    // Single driver of the internal bus
    typedef enum logic [2:0] {
        BUS_NONE, BUS_PC, BUS_MDR, BUS_ALU, BUS_ADDR
    } busSrc_t;

    typedef enum logic [1:0] {
        PC_INCREMENT, PC_ADDER, PC_RESET
    } pcSel_t;

    typedef enum logic {
        ADDR1_PC, ADDR1_SR1
    } addr1Sel_t;

    typedef enum logic {
        ADDR2_ZERO, ADDR2_OFF9
    } addr2Sel_t;

    typedef enum logic [1:0] {
        ALU_ADD, ALU_AND, ALU_NOT, ALU_PASS
    } aluOp_t;

    typedef struct packed {
        logic      ldMar;
        logic      ldMdr;
        logic      ldIr;
        logic      ldBen;
        logic      ldReg;
        logic      ldCc;
        logic      ldPc;
        busSrc_t   busSrc;
        pcSel_t    pcSel;
        addr1Sel_t addr1Sel;
        addr2Sel_t addr2Sel;
        logic      srSel;    // 0: IR[8:6], 1: store source IR[11:9]
        aluOp_t    aluOp;
        logic      memStart; // One cycle, kicks off an APB transfer
        logic      memWrite;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== lc3Control.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3Control (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  run,
    input  lc3IsaPkg::opcode_t    opcode,
    input  logic                  ben,
    input  logic                  memDone,
    output lc3CtrlPkg::ctrlWord_t ctrl,
    output logic                  halted,
    output logic                  invalidOp
);
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN)
            state <= HALT;
        else
            state <= nextState;
    end

    always_comb begin
        nextState = state;
        unique case (state)
            HALT:       if (run) nextState = START;
            START:      if (!run) nextState = FETCH;   // Go on Run release
            FETCH:      nextState = FETCH_WAIT;
            FETCH_WAIT: if (memDone) nextState = LOAD_IR;
            LOAD_IR:    nextState = DECODE;
            DECODE: begin
                case (opcode)
                    OP_BR:                  nextState = BR_TEST;
                    OP_ADD, OP_AND, OP_NOT: nextState = ALU_OP;
                    OP_LD, OP_ST:           nextState = ADDR_MAR;
                    OP_JMP:                 nextState = JMP_PC;
                    default:                nextState = INVALID;
                endcase
            end
            BR_TEST:    nextState = ben ? BR_TAKE : FETCH;
            BR_TAKE:    nextState = FETCH;
            ALU_OP:     nextState = FETCH;
            JMP_PC:     nextState = FETCH;
            ADDR_MAR:   nextState = (opcode == OP_LD) ? LD_WAIT : ST_MDR;
            LD_WAIT:    if (memDone) nextState = LD_REG;
            LD_REG:     nextState = FETCH;
            ST_MDR:     nextState = ST_WAIT;
            ST_WAIT:    if (memDone) nextState = FETCH;
            INVALID:    nextState = INVALID;  // Only reset gets out
            default:    nextState = HALT;
        endcase
    end

    always_comb begin
        ctrl.ldMar    = 1'b0;
        ctrl.ldMdr    = 1'b0;
        ctrl.ldIr     = 1'b0;
        ctrl.ldBen    = 1'b0;
        ctrl.ldReg    = 1'b0;
        ctrl.ldCc     = 1'b0;
        ctrl.ldPc     = 1'b0;
        ctrl.busSrc   = BUS_NONE;
        ctrl.pcSel    = PC_INCREMENT;
        ctrl.addr1Sel = ADDR1_PC;
        ctrl.addr2Sel = ADDR2_ZERO;
        ctrl.srSel    = 1'b0;
        ctrl.aluOp    = ALU_PASS;
        ctrl.memStart = 1'b0;
        ctrl.memWrite = 1'b0;

        unique case (state)
            HALT: begin
                ctrl.pcSel = PC_RESET;
                ctrl.ldPc  = 1'b1;
                ctrl.ldCc  = 1'b1;   // Bus idles at zero, so CC becomes Z
            end
            // MAR <- PC, PC <- PC + 1, start the read
            FETCH: begin
                ctrl.busSrc   = BUS_PC;
                ctrl.ldMar    = 1'b1;
                ctrl.ldPc     = 1'b1;
                ctrl.memStart = 1'b1;
            end
            LOAD_IR: begin
                ctrl.busSrc = BUS_MDR;
                ctrl.ldIr   = 1'b1;
            end
            DECODE: ctrl.ldBen = 1'b1;
            BR_TAKE: begin
                ctrl.addr2Sel = ADDR2_OFF9;
                ctrl.pcSel    = PC_ADDER;
                ctrl.ldPc     = 1'b1;
            end
            ALU_OP: begin
                case (opcode)
                    OP_AND:  ctrl.aluOp = ALU_AND;
                    OP_NOT:  ctrl.aluOp = ALU_NOT;
                    default: ctrl.aluOp = ALU_ADD;
                endcase
                ctrl.busSrc = BUS_ALU;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
            end
            // PC <- BaseR + 0
            JMP_PC: begin
                ctrl.addr1Sel = ADDR1_SR1;
                ctrl.pcSel    = PC_ADDER;
                ctrl.ldPc     = 1'b1;
            end
            ADDR_MAR: begin
                ctrl.addr2Sel = ADDR2_OFF9;
                ctrl.busSrc   = BUS_ADDR;
                ctrl.ldMar    = 1'b1;
                ctrl.memStart = (opcode == OP_LD); // Loads read right away
            end
            LD_REG: begin
                ctrl.busSrc = BUS_MDR;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
            end
            // MDR <- SR, then write it out
            ST_MDR: begin
                ctrl.srSel    = 1'b1;
                ctrl.busSrc   = BUS_ALU;
                ctrl.ldMdr    = 1'b1;
                ctrl.memStart = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            default: ;
        endcase
    end

    assign halted    = (state == HALT);
    assign invalidOp = (state == INVALID);

    // A new transfer must not be requested while one is in flight
    assert property (@(posedge Clk) disable iff (!rstN)
        state inside {FETCH_WAIT, LD_WAIT, ST_WAIT} |-> !ctrl.memStart);

    assert property (@(posedge Clk) disable iff (!rstN)
        state == INVALID |=> state == INVALID);

endmodule

`default_nettype wire

// ==== lc3PcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3Settings.svh"

module lc3PcUnit (
    input  logic                  Clk,
    input  logic                  rstN,
    input  lc3CtrlPkg::ctrlWord_t ctrl,
    input  lc3IsaPkg::word_t      bus,
    input  lc3IsaPkg::word_t      sr1,
    output lc3IsaPkg::word_t      ir,
    output lc3IsaPkg::word_t      pc,
    output lc3IsaPkg::word_t      addrSum,
    output logic                  ben
);
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;

    cc_t   cc;
    word_t addr1;
    word_t addr2;
    word_t pcNext;

    assign addr1   = (ctrl.addr1Sel == ADDR1_SR1) ? sr1 : pc;
    assign addr2   = (ctrl.addr2Sel == ADDR2_OFF9) ? word_t'(signed'(ir[8:0])) : '0;
    assign addrSum = addr1 + addr2;

    always_comb begin
        case (ctrl.pcSel)
            PC_ADDER: pcNext = addrSum;
            PC_RESET: pcNext = `LC3_PC_RESET;
            default:  pcNext = pc + 1'b1;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc  <= `LC3_PC_RESET;
            cc  <= 3'b010;
            ben <= 1'b0;
        end else begin
            if (ctrl.ldPc)
                pc <= pcNext;
            if (ctrl.ldCc)
                cc <= {bus[$high(bus)], bus == '0, !bus[$high(bus)] && bus != '0};
            if (ctrl.ldBen)
                ben <= |(ir[11:9] & cc);  // n&N | z&Z | p&P
        end
    end

    always_ff @(posedge Clk) begin
        if (ctrl.ldIr)
            ir <= bus;
    end

endmodule

`default_nettype wire

// ==== lc3RegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3Settings.svh"

module lc3RegFile (
    input  logic                  Clk,
    input  logic                  rstN,
    input  lc3CtrlPkg::ctrlWord_t ctrl,
    input  lc3IsaPkg::word_t      ir,
    input  lc3IsaPkg::word_t      bus,
    output lc3IsaPkg::word_t      sr1,
    output lc3IsaPkg::word_t      sr2
);
    import lc3IsaPkg::*;

    word_t   regs [`LC3_NUM_REGS];
    regIdx_t sr1Idx;
    regIdx_t sr2Idx;
    regIdx_t drIdx;

    // Store source shares the DR field
    assign sr1Idx = ctrl.srSel ? ir[11:9] : ir[8:6];
    assign sr2Idx = ir[2:0];
    assign drIdx  = ir[11:9];

    assign sr1 = regs[sr1Idx];
    assign sr2 = regs[sr2Idx];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `LC3_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (ctrl.ldReg) begin
            regs[drIdx] <= bus;
        end
    end

endmodule

`default_nettype wire

// ==== lc3ExecUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3ExecUnit (
    input  lc3CtrlPkg::ctrlWord_t ctrl,
    input  lc3IsaPkg::word_t      ir,
    input  lc3IsaPkg::word_t      sr1,
    input  lc3IsaPkg::word_t      sr2,
    input  lc3IsaPkg::word_t      pc,
    input  lc3IsaPkg::word_t      addrSum,
    input  lc3IsaPkg::word_t      mdr,
    output lc3IsaPkg::word_t      bus
);
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;

    word_t op2;
    word_t aluOut;

    assign op2 = ir[5] ? word_t'(signed'(ir[4:0])) : sr2;  // imm5 mode

    always_comb begin
        unique case (ctrl.aluOp)
            ALU_ADD: aluOut = sr1 + op2;
            ALU_AND: aluOut = sr1 & op2;
            ALU_NOT: aluOut = ~sr1;
            default: aluOut = sr1;   // Pass SR1 for stores
        endcase
    end

    always_comb begin
        case (ctrl.busSrc)
            BUS_PC:   bus = pc;
            BUS_MDR:  bus = mdr;
            BUS_ALU:  bus = aluOut;
            BUS_ADDR: bus = addrSum;
            default:  bus = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== lc3MemPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3MemPort (
    input  logic                  Clk,
    input  logic                  rstN,
    input  lc3CtrlPkg::ctrlWord_t ctrl,
    input  lc3IsaPkg::word_t      bus,
    output lc3IsaPkg::word_t      mdr,
    output logic                  memDone,
    output lc3IsaPkg::word_t      paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output lc3IsaPkg::word_t      pwdata,
    input  lc3IsaPkg::word_t      prdata,
    input  logic                  pready
);
    import lc3IsaPkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbPhase_t;

    apbPhase_t phase;
    word_t     mar;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            phase  <= IDLE;
            pwrite <= 1'b0;
        end else begin
            unique case (phase)
                IDLE: if (ctrl.memStart) begin
                    phase  <= SETUP;
                    pwrite <= ctrl.memWrite;  // Held for the whole transfer
                end
                SETUP:  phase <= ACCESS;
                ACCESS: if (pready) phase <= IDLE;
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (ctrl.ldMar)
            mar <= bus;
        if (ctrl.ldMdr)
            mdr <= bus;
        else if (memDone && !pwrite)
            mdr <= prdata;   // Read data lands with memDone
    end

    assign memDone = (phase == ACCESS) && pready;
    assign psel    = (phase != IDLE);
    assign penable = (phase == ACCESS);
    assign paddr   = mar;
    assign pwdata  = mdr;

    // Address, direction and write data frozen while the slave stalls
    assert property (@(posedge Clk) disable iff (!rstN)
        penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

    assert property (@(posedge Clk) disable iff (!rstN) penable |-> psel);

endmodule

`default_nettype wire

// ==== lc3Core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3Core (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             run,
    output logic             halted,
    output logic             invalidOp,
    output lc3IsaPkg::word_t paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output lc3IsaPkg::word_t pwdata,
    input  lc3IsaPkg::word_t prdata,
    input  logic             pready
);
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;

    ctrlWord_t ctrl;
    word_t     ir;
    word_t     pc;
    word_t     addrSum;
    word_t     sr1;
    word_t     sr2;
    word_t     bus;
    word_t     mdr;
    logic      ben;
    logic      memDone;

    lc3Control uControl (
        .Clk(Clk), .rstN(rstN), .run(run),
        .opcode(opcode_t'(ir[15:12])),   // Opcode field of IR
        .ben(ben), .memDone(memDone),
        .ctrl(ctrl), .halted(halted), .invalidOp(invalidOp)
    );

    lc3PcUnit uPcUnit (
        .Clk(Clk), .rstN(rstN), .ctrl(ctrl), .bus(bus), .sr1(sr1),
        .ir(ir), .pc(pc), .addrSum(addrSum), .ben(ben)
    );

    lc3RegFile uRegFile (
        .Clk(Clk), .rstN(rstN), .ctrl(ctrl), .ir(ir), .bus(bus),
        .sr1(sr1), .sr2(sr2)
    );

    lc3ExecUnit uExecUnit (
        .ctrl(ctrl), .ir(ir), .sr1(sr1), .sr2(sr2), .pc(pc),
        .addrSum(addrSum), .mdr(mdr), .bus(bus)
    );

    lc3MemPort uMemPort (
        .Clk(Clk), .rstN(rstN), .ctrl(ctrl), .bus(bus),
        .mdr(mdr), .memDone(memDone),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

endmodule

`default_nettype wire

// ==== lc3ApbMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3Settings.svh"

module lc3ApbMemory (
    input  logic             Clk,
    input  logic             rstN,
    input  lc3IsaPkg::word_t paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  lc3IsaPkg::word_t pwdata,
    output lc3IsaPkg::word_t prdata,
    output logic             pready
);
    import lc3IsaPkg::*;

    localparam int Depth   = 1 << `LC3_MEM_ADDR_BITS;
    localparam int Base    = `LC3_PC_RESET;
    localparam int MaxWait = 3;

    word_t  image [Depth];
    integer seed     = 32'h3bb5_b32c;
    int     waitLeft = 0;
    logic   readyReg = 1'b0;
    word_t  dataReg  = '0;
    logic [`LC3_MEM_ADDR_BITS-1:0] index;

    assign index  = paddr[`LC3_MEM_ADDR_BITS-1:0];  // Upper address bits alias
    assign pready = readyReg;
    assign prdata = dataReg;

    initial begin
        int a;
        // Opcode 1010 is unused, so a stray fetch stops the core
        for (a = 0; a < Depth; a++)
            image[a] = 16'hA000 | word_t'(a);
        image[Base + 'h00] = 16'h222F;  // LD  R1, 0x230
        image[Base + 'h01] = 16'h242F;  // LD  R2, 0x231
        image[Base + 'h02] = 16'h1642;  // ADD R3, R1, R2
        image[Base + 'h03] = 16'h187D;  // ADD R4, R1, #-3
        image[Base + 'h04] = 16'h5A42;  // AND R5, R1, R2
        image[Base + 'h05] = 16'h9CFF;  // NOT R6, R3
        image[Base + 'h06] = 16'h3631;  // ST  R3, 0x238
        image[Base + 'h07] = 16'h3831;  // ST  R4, 0x239
        image[Base + 'h08] = 16'h3A31;  // ST  R5, 0x23A
        image[Base + 'h09] = 16'h3C31;  // ST  R6, 0x23B
        image[Base + 'h0A] = 16'h0601;  // BRzp +1, CC is N here
        image[Base + 'h0B] = 16'h3230;  // ST  R1, 0x23C
        image[Base + 'h0C] = 16'h0801;  // BRn +1
        image[Base + 'h0D] = 16'h342F;  // ST  R2, 0x23D, skipped
        image[Base + 'h0E] = 16'h2E23;  // LD  R7, 0x232
        image[Base + 'h0F] = 16'hC1C0;  // JMP R7
        image[Base + 'h20] = 16'h361D;  // ST  R3, 0x23E
        image[Base + 'h21] = 16'hD000;  // Invalid opcode 1101
        image[Base + 'h30] = 16'h1234;
        image[Base + 'h31] = 16'h0F0F;
        image[Base + 'h32] = 16'h0220;  // Jump target
    end

    // Responder outputs change on the falling edge
    always @(negedge Clk or negedge rstN) begin
        if (!rstN) begin
            readyReg <= 1'b0;
            waitLeft <= 0;
        end else begin
            dataReg <= image[index];
            if (psel && !penable) begin
                waitLeft <= $unsigned($random(seed)) % (MaxWait + 1);
                readyReg <= 1'b0;
            end else if (psel && penable && !readyReg) begin
                if (waitLeft == 0)
                    readyReg <= 1'b1;
                else
                    waitLeft <= waitLeft - 1;
            end else begin
                readyReg <= 1'b0;
            end
        end
    end

    always @(posedge Clk) begin
        if (psel && penable && pready && pwrite)
            image[index] = pwdata;
    end

endmodule

`default_nettype wire

// ==== lc3CoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3Settings.svh"

module lc3CoreTb;
    import lc3IsaPkg::*;

    localparam int AddrBits = `LC3_MEM_ADDR_BITS;
    localparam int MaxWait  = 3;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t data;
    } apbXfer_t;

    logic  Clk;
    logic  rstN;
    logic  run;
    logic  halted;
    logic  invalidOp;
    word_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
    word_t prdata;
    logic  pready;

    apbXfer_t expected [$];   // Every APB transfer in program order
    string    expName [$];
    int       valueErrors    = 0;
    int       protocolErrors = 0;
    int       cycles         = 0;
    int       cycleLimit     = 100000;
    int       instrCount     = 0;
    logic     runSeen        = 1'b0;

    lc3Core uut (
        .Clk(Clk), .rstN(rstN), .run(run), .halted(halted), .invalidOp(invalidOp),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    lc3ApbMemory memModel (
        .Clk(Clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always @(posedge Clk) cycles <= cycles + 1;

    function automatic word_t signExtend(input word_t v, input int bits);
        logic signed [15:0] t;
        t = v << (16 - bits);
        return t >>> (16 - bits);
    endfunction

    function automatic cc_t ccOf(input word_t v);
        if (v[15])
            return 3'b100;
        else if (v == '0)
            return 3'b010;
        return 3'b001;
    endfunction

    function automatic void pushXfer(input logic write, input word_t addr,
                                     input word_t data, input string name);
        apbXfer_t x;
        x.write = write;
        x.addr  = addr;
        x.data  = data;
        expected.push_back(x);
        expName.push_back(name);
    endfunction

    // Instruction level model run over the preloaded image
    task automatic buildExpected(output int count);
        word_t   m [1 << AddrBits];
        word_t   r [`LC3_NUM_REGS];
        string   writer [`LC3_NUM_REGS];   // Last instruction that wrote each register
        word_t   pcM;
        word_t   instr;
        word_t   ea;
        word_t   op2;
        regIdx_t dr;
        regIdx_t s1;
        cc_t     ccM;
        logic    stop;
        int      i;
        for (i = 0; i < (1 << AddrBits); i++)
            m[i] = memModel.image[i];
        for (i = 0; i < `LC3_NUM_REGS; i++) begin
            r[i]      = '0;
            writer[i] = "reset";
        end
        pcM   = `LC3_PC_RESET;
        ccM   = 3'b010;
        stop  = 1'b0;
        count = 0;
        while (!stop && count < 1000) begin
            instr = m[pcM[AddrBits-1:0]];
            pushXfer(1'b0, pcM, '0, "fetch");
            pcM   = pcM + 1'b1;
            count = count + 1;
            dr    = instr[11:9];
            s1    = instr[8:6];
            ea    = pcM + signExtend(instr, 9);
            op2   = instr[5] ? signExtend(instr, 5) : r[instr[2:0]];
            case (instr[15:12])
                4'b0001: begin  // ADD
                    r[dr]      = r[s1] + op2;
                    ccM        = ccOf(r[dr]);
                    writer[dr] = instr[5] ? "ADD imm" : "ADD reg";
                end
                4'b0101: begin  // AND
                    r[dr]      = r[s1] & op2;
                    ccM        = ccOf(r[dr]);
                    writer[dr] = instr[5] ? "AND imm" : "AND reg";
                end
                4'b1001: begin  // NOT
                    r[dr]      = ~r[s1];
                    ccM        = ccOf(r[dr]);
                    writer[dr] = "NOT";
                end
                4'b0010: begin  // LD
                    pushXfer(1'b0, ea, '0, "LD read");
                    r[dr]      = m[ea[AddrBits-1:0]];
                    ccM        = ccOf(r[dr]);
                    writer[dr] = "LD";
                end
                4'b0011: begin  // ST
                    pushXfer(1'b1, ea, r[dr], {"ST of ", writer[dr]});
                    m[ea[AddrBits-1:0]] = r[dr];
                end
                4'b0000: if (|(instr[11:9] & ccM)) pcM = ea;
                4'b1100: pcM = r[s1];     // JMP
                default: stop = 1'b1;
            endcase
        end
    endtask

    task automatic checkTransfer();
        apbXfer_t want;
        string    name;
        assert (expected.size() != 0) else begin
            protocolErrors++;
            $display("APB transfer to %h after the program should have stopped", paddr);
        end
        if (expected.size() != 0) begin
            want = expected.pop_front();
            name = expName.pop_front();
            assert (pwrite == want.write) else begin
                valueErrors++;
                $display("Fail %s pwrite: expected %0d, actual %0d", name, want.write, pwrite);
            end
            assert (paddr == want.addr) else begin
                valueErrors++;
                $display("Fail %s paddr: expected %h, actual %h", name, want.addr, paddr);
            end
            assert (!want.write || pwdata == want.data) else begin
                valueErrors++;
                $display("Fail %s pwdata: expected %h, actual %h", name, want.data, pwdata);
            end
        end
    endtask

    always @(posedge Clk) begin
        if (rstN && psel && penable && pready)
            checkTransfer();
    end

    assert property (@(posedge Clk) disable iff (!rstN)
        !runSeen |-> !psel && !penable && halted && !invalidOp)
        else begin
            protocolErrors++;
            $display("Core left its halted idle state before Run was pulsed");
        end

    // Setup always turns into access
    assert property (@(posedge Clk) disable iff (!rstN) psel && !penable |=> psel && penable)
        else begin
            protocolErrors++;
            $display("APB setup cycle was not followed by an access cycle");
        end

    assert property (@(posedge Clk) disable iff (!rstN) $rose(penable) |-> $past(psel && !penable))
        else begin
            protocolErrors++;
            $display("APB access cycle started without a setup cycle");
        end

    assert property (@(posedge Clk) disable iff (!rstN)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else begin
            protocolErrors++;
            $display("paddr, pwrite or pwdata changed before pready");
        end

    assert property (@(posedge Clk) disable iff (!rstN) invalidOp |-> !halted && !psel)
        else begin
            protocolErrors++;
            $display("Bus activity or halted seen after the invalid opcode stop");
        end

    task automatic reportAndFinish(input logic timedOut);
        $display("Errors: %0d value, %0d protocol, timeout %0d",
                 valueErrors, protocolErrors, timedOut);
        if (!timedOut && valueErrors == 0 && protocolErrors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    initial begin
        wait (cycles >= cycleLimit);
        $display("Timeout after %0d cycles, the core never reached the invalid opcode", cycles);
        reportAndFinish(1'b1);
    end

    initial begin
        rstN = 1'b0;
        run  = 1'b0;
        repeat (2) @(negedge Clk);
        rstN = 1'b1;
        buildExpected(instrCount);
        cycleLimit = cycles + instrCount * 40 * MaxWait + 200;
        repeat (4) @(negedge Clk);   // Idle window before Run
        run     = 1'b1;
        runSeen = 1'b1;
        @(negedge Clk);
        run = 1'b0;                  // Fetch starts on the falling Run
        while (!invalidOp)
            @(negedge Clk);
        assert (expected.size() == 0) else begin
            protocolErrors++;
            $display("invalidOp rose with %0d APB transfers still expected", expected.size());
        end
        repeat (20) @(negedge Clk);  // Catch any stray transfer
        assert (invalidOp && !halted) else begin
            protocolErrors++;
            $display("Core did not stay in the invalid opcode stop");
        end
        reportAndFinish(1'b0);
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
lc3IsaPkg.sv
lc3CtrlPkg.sv
lc3Control.sv
lc3PcUnit.sv
lc3RegFile.sv
lc3ExecUnit.sv
lc3MemPort.sv
lc3Core.sv
lc3ApbMemory.sv
lc3CoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lc3CoreTb -f vlog.f
./obj_dir/Vlc3CoreTb > sim.log 2>&1
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
